//--- dv/fetch_stim.txt
// program word count, then program words from address 0, then cycle count
// cycle line: ctrl redirect_pc bp_pc  pc inst0 inst1 inst2 inst3 tkn_brnch is_im_jmp brch_full
// ctrl bits from 0: stall_fetch stall_for_jump commit_br mispred_num redirect_en bp_update bp_taken
003A
1000 1001 1002 1003 1004 1005 1006 1007
1008 F01C 100A 100B 100C 100D 100E 100F
1010 9080 1012 1013 1014 1015 1016 1017
1018 1019 101A 101B 101C A010 B020 9030
1020 1021 1022 A040 1024 1025 1026 1027
1028 1029 102A 102B 102C 102D 102E 102F
1030 1031 1032 1033 1034 F005 1036 1037
1038 1039
0016
// straight line
00 0000 0000  0000 1000 1001 1002 1003 0 0 0
00 0000 0000  0004 1004 1005 1006 1007 0 0 0
// immediate jump in slot 1, target 9 + 7
00 0000 0000  0008 1008 F01C 0000 0000 0 4 0
// branch at 17 weakly not taken, then trained to taken
00 0000 0000  0010 1010 9080 1012 1013 0 0 0
64 0000 0011  0014 1014 1015 1016 1017 0 0 0
70 0010 0011  0018 1018 1019 101A 101B 0 0 0
00 0000 0000  0010 1010 9080 0000 0000 4 0 0
04 0000 0000  0019 1019 101A 101B 101C 0 0 0
// third branch in slot 2, then full until a commit
00 0000 0000  001D A010 B020 0000 0000 0 0 0
00 0000 0000  001F 0000 0000 0000 0000 0 0 1
04 0000 0000  001F 0000 0000 0000 0000 0 0 1
00 0000 0000  001F 9030 1020 1021 1022 0 0 0
// third branch in slot 0 holds pc, mispredict frees two
00 0000 0000  0023 0000 0000 0000 0000 0 0 0
0C 0000 0000  0023 0000 0000 0000 0000 0 0 1
00 0000 0000  0023 A040 1024 1025 1026 0 0 0
// stalls, redirect wins over a stall
05 0000 0000  0027 0000 0000 0000 0000 0 0 0
02 0000 0000  0027 0000 0000 0000 0000 0 0 0
11 0030 0000  0027 0000 0000 0000 0000 0 0 0
00 0000 0000  0030 1030 1031 1032 1033 0 0 0
// register jump falls through to slot 2, resolved by redirect
00 0000 0000  0034 1034 F005 0000 0000 0 0 0
12 0000 0000  0036 0000 0000 0000 0000 0 0 0
00 0000 0000  0000 1000 1001 1002 1003 0 0 0

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
   import fetch_pkg::*;
();

   // fields per cycle record in the stim file
   localparam int n_fields = 11;
   localparam int clk_half = 2;
   localparam int clk_per  = 2 * clk_half;

   logic                      clk;
   logic                      rst_n;
   logic                      load_en;
   logic [rom_depth_log2-1:0] load_addr;
   logic [inst_w-1:0]         load_data;
   logic                      stall_fetch;
   logic                      stall_for_jump;
   logic                      commit_br;
   logic                      mispred_num;
   logic                      redirect_en;
   logic [inst_w-1:0]         redirect_pc;
   logic                      bp_update;
   logic [inst_w-1:0]         bp_pc;
   logic                      bp_taken;
   logic [inst_w-1:0]         pc;
   logic [inst_w-1:0]         inst0, inst1, inst2, inst3;
   logic [fetch_width-1:0]    tkn_brnch, is_im_jmp;
   logic                      brch_full;

   // raw stim words with the program first and cycle records after it
   logic [inst_w-1:0] stim [0:511];
   int                n_prog;
   int                n_cyc;
   int                rec;
   int                limit_ns;

   fetch_top uut (
      .clk(clk), .rst_n(rst_n),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .stall_fetch(stall_fetch), .stall_for_jump(stall_for_jump),
      .commit_br(commit_br), .mispred_num(mispred_num),
      .redirect_en(redirect_en), .redirect_pc(redirect_pc),
      .bp_update(bp_update), .bp_pc(bp_pc), .bp_taken(bp_taken),
      .pc(pc), .inst0(inst0), .inst1(inst1), .inst2(inst2), .inst3(inst3),
      .tkn_brnch(tkn_brnch), .is_im_jmp(is_im_jmp), .brch_full(brch_full)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////
   task automatic check_val(input string name, input logic [inst_w-1:0] got,
                            input logic [inst_w-1:0] exp);
      assert (got === exp) else begin
         $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
         $display("FAIL: see errors above");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // ctrl word bits from bit 0 up are stall_fetch, stall_for_jump, commit_br,
   // mispred_num, redirect_en, bp_update and bp_taken
   task automatic drive_inputs(input int b);
      logic [inst_w-1:0] ctrl;
      ctrl = stim[b];
      {bp_taken, bp_update, redirect_en, mispred_num,
       commit_br, stall_for_jump, stall_fetch} = ctrl[6:0];
      redirect_pc = stim[b+1];
      bp_pc       = stim[b+2];
   endtask

   task automatic check_outputs(input int b);
      check_val("pc", pc, stim[b+3]);
      check_val("inst0", inst0, stim[b+4]);
      check_val("inst1", inst1, stim[b+5]);
      check_val("inst2", inst2, stim[b+6]);
      check_val("inst3", inst3, stim[b+7]);
      check_val("tkn_brnch", inst_w'(tkn_brnch), stim[b+8]);
      check_val("is_im_jmp", inst_w'(is_im_jmp), stim[b+9]);
      check_val("brch_full", inst_w'(brch_full), stim[b+10]);
   endtask

   // one word per clock through the load port, pc parked at 0
   task automatic load_program();
      for (int i = 0; i < n_prog; i++) begin
         @(posedge clk);
         #1;
         load_en   = 1'b1;
         load_addr = rom_depth_log2'(i);
         load_data = stim[1+i];
      end
      @(posedge clk);
      #1;
      load_en = 1'b0;
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      rst_n          = 1'b0;
      load_en        = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      stall_fetch    = 1'b0;
      stall_for_jump = 1'b0;
      commit_br      = 1'b0;
      mispred_num    = 1'b0;
      redirect_en    = 1'b0;
      redirect_pc    = '0;
      bp_update      = 1'b0;
      bp_pc          = '0;
      bp_taken       = 1'b0;
      limit_ns       = 0;
      $readmemh("dv/fetch_stim.txt", stim);
      assert (!$isunknown(stim[0]) && stim[0] != '0) else begin
         $display("stimulus file is missing or holds no program");
         $display("FAIL: see errors above");
         $fatal(1, "no stimulus");
      end
      n_prog = int'(stim[0]);
      n_cyc  = int'(stim[n_prog+1]);
      // load, reset and every cycle line, plus slack
      limit_ns = (n_prog + n_cyc + 8) * clk_per + 100;
      // reset stays low through the load and 4 cycles after it
      load_program();
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // drive at edge plus 1, sample at edge plus 3
      for (int c = 0; c < n_cyc; c++) begin
         rec = n_prog + 2 + c * n_fields;
         drive_inputs(rec);
         #2;
         check_outputs(rec);
         @(posedge clk);
         #1;
      end
      $display("PASS: all tests");
      $finish;
   end

   // watchdog armed once the cycle count is known
   initial begin
      wait (limit_ns != 0);
      #(limit_ns);
      $display("timeout: run did not finish within %0d ns", limit_ns);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- hw/branch_handler.sv
`timescale 1ns/1ps

module branch_handler
   import fetch_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [inst_w-1:0]      pc,
   input  logic [inst_w-1:0]      raw0,
   input  logic [inst_w-1:0]      raw1,
   input  logic [inst_w-1:0]      raw2,
   input  logic [inst_w-1:0]      raw3,
   input  logic                   stall_for_jump,
   input  logic                   stall_fetch,
   input  logic [1:0]             pred_to_pcsel,
   input  logic                   commit_br,
   input  logic                   mispred_num,
   output logic                   update_bpred,
   output logic                   pcsel_hold,
   output logic [inst_w-1:0]      pc_bhndlr,
   output logic [inst_w-1:0]      inst0,
   output logic [inst_w-1:0]      inst1,
   output logic [inst_w-1:0]      inst2,
   output logic [inst_w-1:0]      inst3,
   output logic                   brch_full,
   output logic [fetch_width-1:0] tkn_brnch,
   output logic [fetch_width-1:0] is_im_jmp
);

   logic [inst_w-1:0]      raw  [fetch_width];
   logic [inst_w-1:0]      outw [fetch_width];
   logic [cnt_w-1:0]       br_cnt, br_live, dec_amt, cnt_nxt;
   logic                   br_ord;
   logic                   kill;
   logic                   hold_q;
   logic [slot_w:0]        n_issue;
   logic [fetch_width-1:0] squash, third, tkn, imj, out_nz;

   assign raw[0] = raw0;
   assign raw[1] = raw1;
   assign raw[2] = raw2;
   assign raw[3] = raw3;

   ////////////////////
   // slot walk
   ////////////////////
   // slot 0 first, once kill is up every later slot is squashed
   always_comb begin
      kill    = stall_fetch | stall_for_jump | hold_q;
      br_live = br_cnt;
      br_ord  = 1'b0;
      n_issue = '0;
      squash  = '0;
      third   = '0;
      tkn     = '0;
      imj     = '0;
      for (int i = 0; i < fetch_width; i++) begin
         if (kill) begin
            squash[i] = 1'b1;
         end else if (is_branch(raw[i])) begin
            if (br_live >= cnt_w'(max_branches)) begin
               // one branch too many, drop it and the rest
               third[i]  = 1'b1;
               squash[i] = 1'b1;
               kill      = 1'b1;
            end else begin
               br_live = br_live + 1'b1;
               // pred bit 1 for the first branch, bit 0 for the second
               tkn[i]  = br_ord ? pred_to_pcsel[0] : pred_to_pcsel[1];
               br_ord  = 1'b1;
               kill    = tkn[i];
            end
         end else if (is_jump(raw[i])) begin
            // jump issues, the slots behind it do not
            imj[i] = is_imm_jump(raw[i]);
            kill   = 1'b1;
         end
         if (!squash[i]) begin
            n_issue = n_issue + 1'b1;
         end
      end
   end

   // msb is slot 0, same order as the bundle
   always_comb begin
      for (int i = 0; i < fetch_width; i++) begin
         tkn_brnch[fetch_width-1-i] = tkn[i];
         is_im_jmp[fetch_width-1-i] = imj[i];
         outw[i]                    = squash[i] ? '0 : raw[i];
         out_nz[fetch_width-1-i]    = outw[i] != '0;
      end
   end

   assign inst0 = outw[0];
   assign inst1 = outw[1];
   assign inst2 = outw[2];
   assign inst3 = outw[3];

   // restart at the first squashed slot, pc when all are gone
   assign pc_bhndlr    = pc + inst_w'(n_issue);
   assign pcsel_hold   = stall_fetch | stall_for_jump | hold_q | third[0];
   assign update_bpred = br_live != br_cnt;
   assign brch_full    = hold_q;

   ////////////////////
   // in-flight count
   ////////////////////
   // mispredict frees two, plain commit frees one, floor zero
   always_comb begin
      dec_amt = '0;
      if (commit_br) begin
         dec_amt = mispred_num ? cnt_w'(2) : cnt_w'(1);
      end
      cnt_nxt = (br_live > dec_amt) ? br_live - dec_amt : '0;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         br_cnt <= '0;
         hold_q <= 1'b0;
      end else begin
         br_cnt <= cnt_nxt;
         // any commit reopens fetch, a third branch closes it
         if (commit_br) begin
            hold_q <= 1'b0;
         end else if (|third) begin
            hold_q <= 1'b1;
         end
      end
   end

   a_cnt_max: assert property (
      @(posedge clk) disable iff (!rst_n) br_cnt <= cnt_w'(max_branches)
   ) else $error("branch_handler: branch count above limit");

   // a taken slot must reach the output untouched
   a_tkn_live: assert property (
      @(posedge clk) disable iff (!rst_n) (tkn_brnch & ~out_nz) == '0
   ) else $error("branch_handler: taken flag on a squashed slot");

endmodule

//--- hw/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
   import fetch_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [inst_w-1:0] pc,
   input  logic [inst_w-1:0] raw0,
   input  logic [inst_w-1:0] raw1,
   input  logic [inst_w-1:0] raw2,
   input  logic [inst_w-1:0] raw3,
   input  logic              bp_update,
   input  logic [inst_w-1:0] bp_pc,
   input  logic              bp_taken,
   input  logic              update_bpred,
   output logic [1:0]        pred_to_pcsel
);

   logic [1:0]             bht [bht_depth];
   logic [inst_w-1:0]      raw [fetch_width];
   logic                   found0, found1;
   logic [slot_w-1:0]      slot0, slot1;
   logic [bht_index_w-1:0] idx0, idx1, upd_idx;
   logic [1:0]             upd_old;
   logic [inst_w-1:0]      lookup_cnt;

   assign raw[0] = raw0;
   assign raw[1] = raw1;
   assign raw[2] = raw2;
   assign raw[3] = raw3;

   // first two branch slots of the bundle
   always_comb begin
      found0 = 1'b0;
      found1 = 1'b0;
      slot0  = '0;
      slot1  = '0;
      for (int i = 0; i < fetch_width; i++) begin
         if (is_branch(raw[i])) begin
            if (!found0) begin
               found0 = 1'b1;
               slot0  = slot_w'(i);
            end else if (!found1) begin
               found1 = 1'b1;
               slot1  = slot_w'(i);
            end
         end
      end
   end

   // index is the branch's own pc, low bits
   assign idx0 = pc[bht_index_w-1:0] + bht_index_w'(slot0);
   assign idx1 = pc[bht_index_w-1:0] + bht_index_w'(slot1);

   // msb of the counter is the taken guess
   assign pred_to_pcsel = {found0 & bht[idx0][1], found1 & bht[idx1][1]};

   ////////////////////
   // training
   ////////////////////
   assign upd_idx = bp_pc[bht_index_w-1:0];
   assign upd_old = bht[upd_idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < bht_depth; i++) begin
            bht[i] <= ctr_init;
         end
      end else if (bp_update) begin
         // saturate at both ends
         if (bp_taken && upd_old != 2'b11) begin
            bht[upd_idx] <= upd_old + 2'd1;
         end else if (!bp_taken && upd_old != 2'b00) begin
            bht[upd_idx] <= upd_old - 2'd1;
         end
      end
   end

   // lookups that issued at least one branch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lookup_cnt <= '0;
      end else if (update_bpred) begin
         lookup_cnt <= lookup_cnt + 1'b1;
      end
   end

   // a taken update never lowers a counter, not-taken never raises it
   // i.e. no wrap past 11 or 00
   a_ctr_sat: assert property (
      @(posedge clk) disable iff (!rst_n)
      bp_update |=> ($past(bp_taken) ? (bht[$past(upd_idx)] >= $past(upd_old))
                                     : (bht[$past(upd_idx)] <= $past(upd_old)))
   ) else $error("branch_predictor: counter left its range");

   // handler only reports a lookup when a branch was actually seen
   a_lookup_has_branch: assert property (
      @(posedge clk) disable iff (!rst_n)
      (lookup_cnt != $past(lookup_cnt)) |-> $past(found0)
   ) else $error("branch_predictor: lookup counted without a branch");

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

   // word, bundle and slot sizes
   localparam int inst_w      = 16;
   localparam int fetch_width = 4;
   localparam int slot_w      = $clog2(fetch_width);

   // in-flight branch limit, third one gets squashed
   localparam int max_branches = 2;
   localparam int cnt_w        = $clog2(max_branches + 1);

   // instruction memory, word addressed
   localparam int rom_depth_log2 = 8;
   localparam int rom_depth      = 1 << rom_depth_log2;

   // branch history table
   localparam int         bht_index_w = 6;
   localparam int         bht_depth   = 1 << bht_index_w;
   localparam logic [1:0] ctr_init    = 2'b01;

   ////////////////////
   // opcode fields
   ////////////////////
   localparam int                   op_hi         = 15;
   localparam int                   op_lo         = 12;
   localparam logic [op_hi-op_lo:0] jump_op       = '1;
   localparam logic [1:0]           branch_prefix = 2'b10;
   localparam int                   imm_jump_mask = 2;

   // offset fields share the top bit 11
   localparam int off_hi     = 11;
   localparam int br_off_w   = 8;
   localparam int br_off_lo  = off_hi - br_off_w + 1;
   localparam int jmp_off_w  = 10;
   localparam int jmp_off_lo = off_hi - jmp_off_w + 1;

   // conditional branch: 10xx with xx nonzero
   function automatic logic is_branch(input logic [inst_w-1:0] inst);
      return (inst[op_hi -: 2] == branch_prefix) && (inst[op_hi-2 -: 2] != 2'b00);
   endfunction

   function automatic logic is_jump(input logic [inst_w-1:0] inst);
      return inst[op_hi:op_lo] == jump_op;
   endfunction

   // low bits clear means immediate, anything else is register based
   function automatic logic is_imm_jump(input logic [inst_w-1:0] inst);
      return is_jump(inst) && (inst[imm_jump_mask-1:0] == '0);
   endfunction

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
   import fetch_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      load_en,
   input  logic [rom_depth_log2-1:0] load_addr,
   input  logic [inst_w-1:0]         load_data,
   input  logic                      stall_fetch,
   input  logic                      stall_for_jump,
   input  logic                      commit_br,
   input  logic                      mispred_num,
   input  logic                      redirect_en,
   input  logic [inst_w-1:0]         redirect_pc,
   input  logic                      bp_update,
   input  logic [inst_w-1:0]         bp_pc,
   input  logic                      bp_taken,
   output logic [inst_w-1:0]         pc,
   output logic [inst_w-1:0]         inst0,
   output logic [inst_w-1:0]         inst1,
   output logic [inst_w-1:0]         inst2,
   output logic [inst_w-1:0]         inst3,
   output logic [fetch_width-1:0]    tkn_brnch,
   output logic [fetch_width-1:0]    is_im_jmp,
   output logic                      brch_full
);

   // raw bundle and handler to pc path
   logic [inst_w-1:0] raw0, raw1, raw2, raw3;
   logic [1:0]        pred_to_pcsel;
   logic              update_bpred;
   logic              pcsel_hold;
   logic [inst_w-1:0] pc_bhndlr;

   inst_rom u_rom (
      .clk(clk), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .pc(pc), .raw0(raw0), .raw1(raw1), .raw2(raw2), .raw3(raw3)
   );

   branch_predictor u_bpred (
      .clk(clk), .rst_n(rst_n), .pc(pc),
      .raw0(raw0), .raw1(raw1), .raw2(raw2), .raw3(raw3),
      .bp_update(bp_update), .bp_pc(bp_pc), .bp_taken(bp_taken),
      .update_bpred(update_bpred), .pred_to_pcsel(pred_to_pcsel)
   );

   branch_handler u_bhndlr (
      .clk(clk), .rst_n(rst_n), .pc(pc),
      .raw0(raw0), .raw1(raw1), .raw2(raw2), .raw3(raw3),
      .stall_for_jump(stall_for_jump), .stall_fetch(stall_fetch),
      .pred_to_pcsel(pred_to_pcsel), .commit_br(commit_br), .mispred_num(mispred_num),
      .update_bpred(update_bpred), .pcsel_hold(pcsel_hold), .pc_bhndlr(pc_bhndlr),
      .inst0(inst0), .inst1(inst1), .inst2(inst2), .inst3(inst3),
      .brch_full(brch_full), .tkn_brnch(tkn_brnch), .is_im_jmp(is_im_jmp)
   );

   // targets come from the raw words, marked slots are never squashed
   next_pc_logic u_npc (
      .clk(clk), .rst_n(rst_n), .pcsel_hold(pcsel_hold), .pc_bhndlr(pc_bhndlr),
      .tkn_brnch(tkn_brnch), .is_im_jmp(is_im_jmp),
      .raw0(raw0), .raw1(raw1), .raw2(raw2), .raw3(raw3),
      .redirect_en(redirect_en), .redirect_pc(redirect_pc), .pc(pc)
   );

endmodule

//--- hw/inst_rom.sv
`timescale 1ns/1ps

module inst_rom
   import fetch_pkg::*;
(
   input  logic                      clk,
   input  logic                      load_en,
   input  logic [rom_depth_log2-1:0] load_addr,
   input  logic [inst_w-1:0]         load_data,
   input  logic [inst_w-1:0]         pc,
   output logic [inst_w-1:0]         raw0,
   output logic [inst_w-1:0]         raw1,
   output logic [inst_w-1:0]         raw2,
   output logic [inst_w-1:0]         raw3
);

   logic [inst_w-1:0]         mem [rom_depth];
   logic [inst_w-1:0]         rd  [fetch_width];
   logic [rom_depth_log2-1:0] base;

   // program load port, testbench only
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // four consecutive words, address wraps at the top
   assign base = pc[rom_depth_log2-1:0];

   always_comb begin
      for (int i = 0; i < fetch_width; i++) begin
         rd[i] = mem[base + rom_depth_log2'(i)];
      end
   end

   assign raw0 = rd[0];
   assign raw1 = rd[1];
   assign raw2 = rd[2];
   assign raw3 = rd[3];

   // fetch sits at pc 0 while in reset
   // any load once pc has started moving would race the fetch path
   a_load_in_reset: assert property (
      @(posedge clk) load_en |-> (pc == '0) && $stable(pc)
   ) else $error("inst_rom: load_en while fetch is running");

endmodule

//--- hw/next_pc_logic.sv
`timescale 1ns/1ps

module next_pc_logic
   import fetch_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pcsel_hold,
   input  logic [inst_w-1:0]      pc_bhndlr,
   input  logic [fetch_width-1:0] tkn_brnch,
   input  logic [fetch_width-1:0] is_im_jmp,
   input  logic [inst_w-1:0]      raw0,
   input  logic [inst_w-1:0]      raw1,
   input  logic [inst_w-1:0]      raw2,
   input  logic [inst_w-1:0]      raw3,
   input  logic                   redirect_en,
   input  logic [inst_w-1:0]      redirect_pc,
   output logic [inst_w-1:0]      pc
);

   logic [inst_w-1:0] raw [fetch_width];
   logic [inst_w-1:0] slot_pc, off, target, pc_nxt;
   logic              target_vld;

   assign raw[0] = raw0;
   assign raw[1] = raw1;
   assign raw[2] = raw2;
   assign raw[3] = raw3;

   ////////////////////
   // target adder
   ////////////////////
   // walk last slot to first so the lowest marked slot wins
   always_comb begin
      slot_pc    = pc;
      off        = '0;
      target_vld = 1'b0;
      for (int i = fetch_width - 1; i >= 0; i--) begin
         if (tkn_brnch[fetch_width-1-i] || is_im_jmp[fetch_width-1-i]) begin
            target_vld = 1'b1;
            slot_pc    = pc + inst_w'(i);
            if (is_im_jmp[fetch_width-1-i]) begin
               // jump offset bits 11:2, sign extended
               off = {{(inst_w-jmp_off_w){raw[i][off_hi]}}, raw[i][off_hi:jmp_off_lo]};
            end else begin
               // branch offset bits 11:4
               off = {{(inst_w-br_off_w){raw[i][off_hi]}}, raw[i][off_hi:br_off_lo]};
            end
         end
      end
      target = slot_pc + off;
   end

   // redirect, then hold, then target, then sequential
   always_comb begin
      if (redirect_en) begin
         pc_nxt = redirect_pc;
      end else if (pcsel_hold) begin
         pc_nxt = pc;
      end else if (target_vld) begin
         pc_nxt = target;
      end else begin
         pc_nxt = pc_bhndlr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= pc_nxt;
      end
   end

   // handler kills behind the first taken or jump slot
   // so one target source at most
   a_one_target: assert property (
      @(posedge clk) disable iff (!rst_n) $onehot0({tkn_brnch, is_im_jmp})
   ) else $error("next_pc_logic: more than one target source");

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module fetch_tb -f vlog.f; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vfetch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
   echo "result: pass"
   exit 0
else
   echo "result: fail"
   exit 1
fi

//--- vlog.f
hw/fetch_pkg.sv
hw/inst_rom.sv
hw/branch_predictor.sv
hw/branch_handler.sv
hw/next_pc_logic.sv
hw/fetch_top.sv
dv/fetch_tb.sv
